// ==== hw/malloc_pkg.sv ====
`default_nettype none

package malloc_pkg;

    localparam int BLOCK_BYTES     = 64;
    localparam int BLOCKS_PER_PAGE = 32;
    localparam int NUM_PAGES       = 4;
    localparam int CLASS_COUNT     = 4;
    localparam int DATA_BASE       = 256;
    localparam int FIFO_DEPTH      = 8;

    typedef logic [31:0]                pointer_t;
    typedef logic [15:0]                size_t;
    typedef logic [1:0]                 class_t;
    typedef logic [7:0]                 blocks_t;
    typedef logic [1:0]                 page_t;
    typedef logic [BLOCKS_PER_PAGE-1:0] bitmap_t;

    typedef struct packed {
        pointer_t start;
        blocks_t  length;
    } chunk_t;

    // msb is the valid flag, low bits the class index
    function automatic logic [2:0] size_to_class(input size_t size);
        logic [2:0] sel;
        sel = 3'b000;
        for (int c = CLASS_COUNT - 1; c >= 0; c--) begin
            if (size != 0 && int'(size) <= (BLOCK_BYTES << c)) begin
                sel = {1'b1, class_t'(c)};
            end
        end
        return sel;
    endfunction

    function automatic blocks_t class_blocks(input class_t cls);
        return blocks_t'(1) << cls;
    endfunction

endpackage

`default_nettype wire

// ==== hw/bitmap_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface bitmap_if;
    import malloc_pkg::*;

    logic    req;
    logic    we;
    page_t   page;
    bitmap_t wdata;
    logic    gnt;
    bitmap_t rdata;

    // engine side, req held across the whole read-modify-write
    modport master (
        output req, we, page, wdata,
        input  gnt, rdata
    );

    modport slave (
        input  req, we, page, wdata,
        output gnt, rdata
    );

endinterface

`default_nettype wire

// ==== hw/class_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module class_fifo #(
    parameter int DEPTH = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               push,
    input  malloc_pkg::chunk_t push_chunk,
    output logic               full,
    input  logic               pop,
    output malloc_pkg::chunk_t pop_chunk,
    output logic               empty
);
    import malloc_pkg::*;

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    chunk_t        mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;

    assign full      = (count == DEPTH);
    assign empty     = (count == 0);
    assign pop_chunk = mem[rd_ptr];

    // callers honour full and empty
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_chunk;
        end
    end

endmodule

`default_nettype wire

// ==== hw/free_list.sv ====
`timescale 1ns/1ps
`default_nettype none

module free_list #(
    parameter int NUM_PAGES = malloc_pkg::NUM_PAGES
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               pop_req,
    input  malloc_pkg::class_t pop_class,
    output logic               pop_ack,
    output logic               pop_empty,
    output malloc_pkg::chunk_t pop_chunk,
    input  logic               push_a,
    input  malloc_pkg::class_t push_a_class,
    input  malloc_pkg::chunk_t push_a_chunk,
    input  logic               push_f,
    input  malloc_pkg::class_t push_f_class,
    input  malloc_pkg::chunk_t push_f_chunk
);
    import malloc_pkg::*;

    localparam int CNT_W = $clog2(NUM_PAGES + 1);

    logic [CLASS_COUNT-1:0] fifo_push;
    logic [CLASS_COUNT-1:0] fifo_pop;
    logic [CLASS_COUNT-1:0] fifo_full;
    logic [CLASS_COUNT-1:0] fifo_empty;
    chunk_t                 fifo_in [CLASS_COUNT];
    chunk_t                 fifo_head [CLASS_COUNT];
    logic [CNT_W-1:0]       next_page;
    chunk_t                 fresh;
    logic                   hold_valid;
    class_t                 hold_class;
    chunk_t                 hold_chunk;
    logic                   f_valid;
    class_t                 f_class;
    chunk_t                 f_chunk;

    // free-side source, a held entry drains before new pushes
    assign f_valid = hold_valid | push_f;
    assign f_class = hold_valid ? hold_class : push_f_class;
    assign f_chunk = hold_valid ? hold_chunk : push_f_chunk;

    assign fresh.start  = pointer_t'(DATA_BASE + int'(next_page) * BLOCKS_PER_PAGE);
    assign fresh.length = blocks_t'(BLOCKS_PER_PAGE);

    // --------------------------------------------------
    // one FIFO per size class
    for (genvar i = 0; i < CLASS_COUNT; i++) begin : g_class
        assign fifo_push[i] = ~fifo_full[i] &
            ((push_a && push_a_class == class_t'(i)) ||
             (f_valid && !push_a && f_class == class_t'(i)));
        assign fifo_in[i]   = push_a ? push_a_chunk : f_chunk;
        assign fifo_pop[i]  = pop_req && pop_class == class_t'(i) && !fifo_empty[i];

        class_fifo #(
            .DEPTH(FIFO_DEPTH)
        ) u_fifo (
            .clk        (clk),
            .rst        (rst),
            .push       (fifo_push[i]),
            .push_chunk (fifo_in[i]),
            .full       (fifo_full[i]),
            .pop        (fifo_pop[i]),
            .pop_chunk  (fifo_head[i]),
            .empty      (fifo_empty[i])
        );
    end

    // --------------------------------------------------
    // pop port and fresh-page counter
    always_ff @(posedge clk) begin
        if (rst) begin
            pop_ack    <= 1'b0;
            pop_empty  <= 1'b0;
            next_page  <= '0;
            hold_valid <= 1'b0;
        end else begin
            pop_ack    <= pop_req;
            hold_valid <= push_a & f_valid;
            if (pop_req) begin
                if (!fifo_empty[pop_class]) begin
                    pop_empty <= 1'b0;
                end else if (next_page < NUM_PAGES) begin
                    pop_empty <= 1'b0;
                    next_page <= next_page + 1'b1;
                end else begin
                    pop_empty <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop_req) begin
            pop_chunk <= !fifo_empty[pop_class] ? fifo_head[pop_class] : fresh;
        end
        if (push_a && !hold_valid) begin
            hold_class <= push_f_class;
            hold_chunk <= push_f_chunk;
        end
    end

endmodule

`default_nettype wire

// ==== hw/bitmap_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module bitmap_store #(
    parameter int NUM_PAGES = malloc_pkg::NUM_PAGES
) (
    input logic     clk,
    input logic     rst,
    bitmap_if.slave free_side,
    bitmap_if.slave alloc_side
);
    import malloc_pkg::*;

    bitmap_t words [NUM_PAGES];
    logic    gnt_f;
    logic    gnt_a;
    page_t   rd_page;
    bitmap_t rd_word;

    // --------------------------------------------------
    // locking arbiter, the free side wins a tie
    always_ff @(posedge clk) begin
        if (rst) begin
            gnt_f <= 1'b0;
            gnt_a <= 1'b0;
        end else if (gnt_f) begin
            gnt_f <= free_side.req;
        end else if (gnt_a) begin
            gnt_a <= alloc_side.req;
        end else if (free_side.req) begin
            gnt_f <= 1'b1;
        end else if (alloc_side.req) begin
            gnt_a <= 1'b1;
        end
    end

    assign free_side.gnt  = gnt_f;
    assign alloc_side.gnt = gnt_a;

    // --------------------------------------------------
    // word array, read tracks the owner's page
    assign rd_page = gnt_a ? alloc_side.page : free_side.page;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int p = 0; p < NUM_PAGES; p++) begin
                words[p] <= '0;
            end
        end else if (gnt_f && free_side.we) begin
            words[free_side.page] <= free_side.wdata;
        end else if (gnt_a && alloc_side.we) begin
            words[alloc_side.page] <= alloc_side.wdata;
        end
    end

    always_ff @(posedge clk) begin
        rd_word <= words[rd_page];
    end

    assign free_side.rdata  = rd_word;
    assign alloc_side.rdata = rd_word;

endmodule

`default_nettype wire

// ==== hw/alloc_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module alloc_engine (
    input  logic                 clk,
    input  logic                 rst,
    input  malloc_pkg::size_t    req_data,
    input  logic                 req_valid,
    output logic                 req_ready,
    output malloc_pkg::pointer_t malloc_pointer,
    output logic                 malloc_valid,
    output logic                 malloc_failed,
    input  logic                 malloc_ready,
    output logic                 alloc_error,
    output logic                 pop_req,
    output malloc_pkg::class_t   pop_class,
    input  logic                 pop_ack,
    input  logic                 pop_empty,
    input  malloc_pkg::chunk_t   pop_chunk,
    output logic                 push_a,
    output malloc_pkg::class_t   push_a_class,
    output malloc_pkg::chunk_t   push_a_chunk,
    bitmap_if.master             bm
);
    import malloc_pkg::*;

    localparam int OFF_W = $clog2(BLOCKS_PER_PAGE);

    typedef enum logic [2:0] {
        S_IDLE, S_POP, S_WAIT_POP, S_BM_REQ, S_BM_RMW, S_RESULT, S_PUSH
    } state_t;

    state_t           state;
    logic [2:0]       req_sel;
    class_t           cls;
    chunk_t           chunk;
    logic             failed;
    blocks_t          need;
    pointer_t         rel;
    logic [OFF_W-1:0] offset;
    bitmap_t          mask;

    assign req_sel = size_to_class(req_data);
    assign need    = class_blocks(cls);
    assign rel     = chunk.start - pointer_t'(DATA_BASE);
    assign offset  = OFF_W'(rel % BLOCKS_PER_PAGE);
    assign mask    = bitmap_t'((1 << need) - 1) << offset;

    assign req_ready      = (state == S_IDLE);
    assign pop_req        = (state == S_POP);
    assign pop_class      = cls;
    assign malloc_valid   = (state == S_RESULT);
    assign malloc_failed  = failed;
    assign malloc_pointer = chunk.start;

    // remainder starts right after the returned chunk
    assign push_a       = (state == S_PUSH);
    assign push_a_class = cls;
    assign push_a_chunk = {chunk.start + pointer_t'(need), chunk.length - need};

    assign bm.req   = (state == S_BM_REQ) || (state == S_BM_RMW);
    assign bm.we    = (state == S_BM_RMW);
    assign bm.page  = page_t'(rel / BLOCKS_PER_PAGE);
    assign bm.wdata = bm.rdata | mask;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= S_IDLE;
            failed      <= 1'b0;
            alloc_error <= 1'b0;
        end else begin
            alloc_error <= 1'b0;
            case (state)
                S_IDLE: if (req_valid) begin
                    failed <= ~req_sel[2];
                    state  <= req_sel[2] ? S_POP : S_RESULT;
                end
                S_POP: state <= S_WAIT_POP;
                S_WAIT_POP: if (pop_ack) begin
                    failed <= pop_empty;
                    state  <= pop_empty ? S_RESULT : S_BM_REQ;
                end
                S_BM_REQ: if (bm.gnt) state <= S_BM_RMW;
                S_BM_RMW: begin
                    // blocks of a free chunk must all be clear
                    alloc_error <= |(bm.rdata & mask);
                    state       <= S_RESULT;
                end
                S_RESULT: if (malloc_ready) begin
                    state <= (!failed && chunk.length >= 2 * need) ? S_PUSH : S_IDLE;
                end
                S_PUSH:  state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && req_valid) begin
            cls   <= req_sel[1:0];
            chunk <= '0;
        end else if (state == S_WAIT_POP && pop_ack && !pop_empty) begin
            chunk <= pop_chunk;
        end
    end

endmodule

`default_nettype wire

// ==== hw/free_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module free_engine (
    input  logic                 clk,
    input  logic                 rst,
    input  malloc_pkg::pointer_t free_pointer,
    input  malloc_pkg::size_t    free_size,
    input  logic                 free_valid,
    output logic                 free_ready,
    output logic                 free_error,
    output logic                 push_f,
    output malloc_pkg::class_t   push_f_class,
    output malloc_pkg::chunk_t   push_f_chunk,
    bitmap_if.master             bm
);
    import malloc_pkg::*;

    localparam int OFF_W    = $clog2(BLOCKS_PER_PAGE);
    localparam int DATA_END = DATA_BASE + NUM_PAGES * BLOCKS_PER_PAGE;

    typedef enum logic [2:0] {S_IDLE, S_BM_REQ, S_BM_RMW, S_PUSH, S_REJECT} state_t;

    state_t           state;
    logic [2:0]       in_sel;
    pointer_t         in_rel;
    logic             in_ok;
    pointer_t         ptr;
    class_t           cls;
    blocks_t          need;
    pointer_t         rel;
    logic [OFF_W-1:0] offset;
    bitmap_t          mask;
    logic             owned;

    // chunk must sit in the data pages without crossing a page end
    assign in_sel = size_to_class(free_size);
    assign in_rel = free_pointer - pointer_t'(DATA_BASE);
    assign in_ok  = in_sel[2] && free_pointer >= pointer_t'(DATA_BASE) &&
                    free_pointer < pointer_t'(DATA_END) &&
                    (in_rel % BLOCKS_PER_PAGE) + class_blocks(in_sel[1:0]) <= BLOCKS_PER_PAGE;

    assign need   = class_blocks(cls);
    assign rel    = ptr - pointer_t'(DATA_BASE);
    assign offset = OFF_W'(rel % BLOCKS_PER_PAGE);
    assign mask   = bitmap_t'((1 << need) - 1) << offset;
    assign owned  = (bm.rdata & mask) == mask;

    assign free_ready   = (state == S_IDLE);
    assign free_error   = (state == S_REJECT);
    assign push_f       = (state == S_PUSH);
    assign push_f_class = cls;
    assign push_f_chunk = {ptr, need};

    assign bm.req   = (state == S_BM_REQ) || (state == S_BM_RMW);
    assign bm.we    = (state == S_BM_RMW) && owned;
    assign bm.page  = page_t'(rel / BLOCKS_PER_PAGE);
    assign bm.wdata = bm.rdata & ~mask;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:   if (free_valid) state <= in_ok ? S_BM_REQ : S_REJECT;
                S_BM_REQ: if (bm.gnt) state <= S_BM_RMW;
                S_BM_RMW: state <= owned ? S_PUSH : S_REJECT;
                default:  state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && free_valid) begin
            ptr <= free_pointer;
            cls <= in_sel[1:0];
        end
    end

endmodule

`default_nettype wire

// ==== hw/malloc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module malloc_top #(
    parameter int NUM_PAGES = malloc_pkg::NUM_PAGES
) (
    input  logic                 clk,
    input  logic                 rst,
    input  malloc_pkg::size_t    req_data,
    input  logic                 req_valid,
    output logic                 req_ready,
    output malloc_pkg::pointer_t malloc_pointer,
    output logic                 malloc_valid,
    output logic                 malloc_failed,
    input  logic                 malloc_ready,
    input  malloc_pkg::pointer_t free_pointer,
    input  malloc_pkg::size_t    free_size,
    input  logic                 free_valid,
    output logic                 free_ready,
    output logic                 free_error,
    output logic                 alloc_error
);
    import malloc_pkg::*;

    logic   pop_req;
    class_t pop_class;
    logic   pop_ack;
    logic   pop_empty;
    chunk_t pop_chunk;
    logic   push_a;
    class_t push_a_class;
    chunk_t push_a_chunk;
    logic   push_f;
    class_t push_f_class;
    chunk_t push_f_chunk;

    bitmap_if alloc_bm ();
    bitmap_if free_bm ();

    // --------------------------------------------------
    // engines
    alloc_engine u_alloc_engine (
        .clk (clk), .rst (rst),
        .req_data (req_data), .req_valid (req_valid), .req_ready (req_ready),
        .malloc_pointer (malloc_pointer), .malloc_valid (malloc_valid),
        .malloc_failed (malloc_failed), .malloc_ready (malloc_ready),
        .alloc_error (alloc_error),
        .pop_req (pop_req), .pop_class (pop_class), .pop_ack (pop_ack),
        .pop_empty (pop_empty), .pop_chunk (pop_chunk),
        .push_a (push_a), .push_a_class (push_a_class), .push_a_chunk (push_a_chunk),
        .bm (alloc_bm.master)
    );

    free_engine u_free_engine (
        .clk (clk), .rst (rst),
        .free_pointer (free_pointer), .free_size (free_size),
        .free_valid (free_valid), .free_ready (free_ready), .free_error (free_error),
        .push_f (push_f), .push_f_class (push_f_class), .push_f_chunk (push_f_chunk),
        .bm (free_bm.master)
    );

    // --------------------------------------------------
    // shared state
    free_list #(.NUM_PAGES(NUM_PAGES)) u_free_list (
        .clk (clk), .rst (rst),
        .pop_req (pop_req), .pop_class (pop_class), .pop_ack (pop_ack),
        .pop_empty (pop_empty), .pop_chunk (pop_chunk),
        .push_a (push_a), .push_a_class (push_a_class), .push_a_chunk (push_a_chunk),
        .push_f (push_f), .push_f_class (push_f_class), .push_f_chunk (push_f_chunk)
    );

    bitmap_store #(.NUM_PAGES(NUM_PAGES)) u_bitmap_store (
        .clk        (clk),
        .rst        (rst),
        .free_side  (free_bm.slave),
        .alloc_side (alloc_bm.slave)
    );

endmodule

`default_nettype wire

// ==== test/clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== test/malloc_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module malloc_tb;
    import malloc_pkg::*;

    typedef struct packed {
        logic     is_free;
        size_t    size;
        pointer_t ptr;
        logic     flag;
    } op_t;

    logic     clk;
    logic     rst;
    size_t    req_data;
    logic     req_valid;
    logic     req_ready;
    pointer_t malloc_pointer;
    logic     malloc_valid;
    logic     malloc_failed;
    logic     malloc_ready;
    pointer_t free_pointer;
    size_t    free_size;
    logic     free_valid;
    logic     free_ready;
    logic     free_error;
    logic     alloc_error;

    op_t      ops [$];
    int       errors;
    integer   seed = 59;

    // reference model of the allocator state
    chunk_t   model_fifo [CLASS_COUNT][$];
    bitmap_t  bitmap_model [NUM_PAGES];
    int       pages_used;

    clock_gen u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    malloc_top #(
        .NUM_PAGES(NUM_PAGES)
    ) u_malloc_top (
        .clk            (clk),
        .rst            (rst),
        .req_data       (req_data),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .malloc_pointer (malloc_pointer),
        .malloc_valid   (malloc_valid),
        .malloc_failed  (malloc_failed),
        .malloc_ready   (malloc_ready),
        .free_pointer   (free_pointer),
        .free_size      (free_size),
        .free_valid     (free_valid),
        .free_ready     (free_ready),
        .free_error     (free_error),
        .alloc_error    (alloc_error)
    );

    // --------------------------------------------------
    // compare tasks

    task automatic check_pointer(input string name, input pointer_t exp, input pointer_t act);
        if (act !== exp) begin
            $display("error %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    // --------------------------------------------------
    // model

    // smallest class whose block count covers the size
    function automatic logic size_class(input size_t size, output class_t cls);
        logic found;
        found = 1'b0;
        cls   = '0;
        for (int c = 0; c < CLASS_COUNT; c++) begin
            if (!found && int'(size) <= (BLOCK_BYTES << c)) begin
                cls   = class_t'(c);
                found = 1'b1;
            end
        end
        return found && size != 0;
    endfunction

    function automatic bitmap_t block_mask(input int off, input int n);
        bitmap_t m;
        m = '0;
        for (int b = 0; b < n; b++) begin
            m[off + b] = 1'b1;
        end
        return m;
    endfunction

    task automatic predict_alloc(input size_t size, output pointer_t ptr,
                                 output logic failed, output logic overlap);
        class_t  cls;
        chunk_t  ch;
        chunk_t  rest;
        int      n;
        int      rel;
        bitmap_t m;
        ptr     = '0;
        failed  = 1'b0;
        overlap = 1'b0;
        if (!size_class(size, cls)) begin
            failed = 1'b1;
            return;
        end
        n = 1 << cls;
        if (model_fifo[cls].size() > 0) begin
            ch = model_fifo[cls].pop_front();
        end else if (pages_used < NUM_PAGES) begin
            ch.start  = pointer_t'(DATA_BASE + pages_used * BLOCKS_PER_PAGE);
            ch.length = blocks_t'(BLOCKS_PER_PAGE);
            pages_used++;
        end else begin
            failed = 1'b1;
            return;
        end
        rel     = int'(ch.start) - DATA_BASE;
        m       = block_mask(rel % BLOCKS_PER_PAGE, n);
        overlap = |(bitmap_model[rel / BLOCKS_PER_PAGE] & m);
        bitmap_model[rel / BLOCKS_PER_PAGE] |= m;
        ptr = ch.start;
        // remainder goes back while it still holds two class units
        if (int'(ch.length) >= 2 * n) begin
            rest.start  = ch.start + pointer_t'(n);
            rest.length = ch.length - blocks_t'(n);
            model_fifo[cls].push_back(rest);
        end
    endtask

    task automatic predict_free(input pointer_t ptr, input size_t size, output logic rejected);
        class_t  cls;
        chunk_t  ch;
        int      n;
        int      rel;
        int      page;
        bitmap_t m;
        rejected = 1'b1;
        if (!size_class(size, cls)) return;
        if (ptr < pointer_t'(DATA_BASE)) return;
        if (ptr >= pointer_t'(DATA_BASE + NUM_PAGES * BLOCKS_PER_PAGE)) return;
        n    = 1 << cls;
        rel  = int'(ptr) - DATA_BASE;
        page = rel / BLOCKS_PER_PAGE;
        if (rel % BLOCKS_PER_PAGE + n > BLOCKS_PER_PAGE) return;
        m = block_mask(rel % BLOCKS_PER_PAGE, n);
        if ((bitmap_model[page] & m) != m) return;
        rejected = 1'b0;
        bitmap_model[page] &= ~m;
        if (model_fifo[cls].size() >= FIFO_DEPTH) begin
            $display("stimulus overflows the FIFO of class %0d", cls);
            errors++;
        end else begin
            ch.start  = ptr;
            ch.length = blocks_t'(n);
            model_fifo[cls].push_back(ch);
        end
    endtask

    // --------------------------------------------------
    // table of operations

    task automatic add_alloc(input int size, input logic fails);
        op_t e;
        e.is_free = 1'b0;
        e.size    = size_t'(size);
        e.ptr     = '0;
        e.flag    = fails;
        ops.push_back(e);
    endtask

    task automatic add_free(input int ptr, input int size, input logic rejected);
        op_t e;
        e.is_free = 1'b1;
        e.size    = size_t'(size);
        e.ptr     = pointer_t'(ptr);
        e.flag    = rejected;
        ops.push_back(e);
    endtask

    // flag column is malloc_failed for an alloc and free_error for a free
    task automatic load_table();
        add_alloc( 64, 1'b0);
        add_alloc( 64, 1'b0);
        add_alloc( 64, 1'b0);
        add_alloc(100, 1'b0);
        add_alloc(100, 1'b0);
        add_alloc(  0, 1'b1);
        add_alloc(513, 1'b1);
        add_free(257,  64, 1'b0);
        add_alloc( 64, 1'b0);
        add_alloc( 64, 1'b0);
        add_alloc( 64, 1'b0);
        add_free(290, 100, 1'b0);
        add_free(290, 100, 1'b1);
        add_free(100,  64, 1'b1);
        add_free(400,  64, 1'b1);
        add_free(256,   0, 1'b1);
        add_alloc(100, 1'b0);
        add_alloc(100, 1'b0);
        for (int k = 0; k < 8; k++) begin
            add_alloc(512, 1'b0);
        end
        add_alloc(512, 1'b1);
        add_alloc(256, 1'b1);
        add_free(352, 512, 1'b0);
        add_alloc(512, 1'b0);
        add_alloc( 64, 1'b0);
        add_free(261,  64, 1'b0);
        add_free(261,  64, 1'b1);
        add_free(287, 100, 1'b1);
        add_alloc(512, 1'b1);
    endtask

    // --------------------------------------------------
    // drivers

    task automatic run_alloc(input int idx, input op_t e);
        string    name;
        pointer_t exp_ptr;
        logic     exp_fail;
        logic     exp_overlap;
        logic     seen_error;
        int       delay;
        name = $sformatf("op %0d alloc size %0d", idx, e.size);
        predict_alloc(e.size, exp_ptr, exp_fail, exp_overlap);
        check_flag({name, " model failed"}, e.flag, exp_fail);
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        @(posedge clk);
        req_valid <= 1'b1;
        req_data  <= e.size;
        @(posedge clk);
        req_valid  <= 1'b0;
        seen_error = 1'b0;
        do begin
            @(negedge clk);
            seen_error |= alloc_error;
        end while (!malloc_valid);
        check_flag({name, " malloc_failed"}, e.flag, malloc_failed);
        if (!e.flag) check_pointer(name, exp_ptr, malloc_pointer);
        // back-pressure, the result must hold
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) begin
            @(negedge clk);
            seen_error |= alloc_error;
            check_flag({name, " held malloc_valid"}, 1'b1, malloc_valid);
            check_flag({name, " held req_ready"}, 1'b0, req_ready);
            if (!e.flag) check_pointer({name, " held"}, exp_ptr, malloc_pointer);
        end
        check_flag({name, " alloc_error"}, exp_overlap, seen_error);
        @(posedge clk);
        malloc_ready <= 1'b1;
        @(posedge clk);
        malloc_ready <= 1'b0;
    endtask

    task automatic run_free(input int idx, input op_t e);
        string name;
        logic  exp_reject;
        logic  seen_error;
        name = $sformatf("op %0d free %0d size %0d", idx, e.ptr, e.size);
        predict_free(e.ptr, e.size, exp_reject);
        check_flag({name, " model rejected"}, e.flag, exp_reject);
        @(negedge clk);
        while (!free_ready) @(negedge clk);
        @(posedge clk);
        free_valid   <= 1'b1;
        free_pointer <= e.ptr;
        free_size    <= e.size;
        @(posedge clk);
        free_valid <= 1'b0;
        seen_error = 1'b0;
        do begin
            @(negedge clk);
            seen_error |= free_error;
        end while (!free_ready);
        check_flag({name, " free_error"}, e.flag, seen_error);
    endtask

    // --------------------------------------------------
    // main sequence and watchdog

    initial begin
        req_data     = '0;
        req_valid    = 1'b0;
        malloc_ready = 1'b0;
        free_pointer = '0;
        free_size    = '0;
        free_valid   = 1'b0;
        errors       = 0;
        pages_used   = 0;
        for (int p = 0; p < NUM_PAGES; p++) begin
            bitmap_model[p] = '0;
        end
        load_table();
        while (rst !== 1'b0) @(posedge clk);
        @(negedge clk);
        check_flag("reset req_ready", 1'b1, req_ready);
        check_flag("reset free_ready", 1'b1, free_ready);
        check_flag("reset malloc_valid", 1'b0, malloc_valid);
        check_flag("reset free_error", 1'b0, free_error);
        check_flag("reset alloc_error", 1'b0, alloc_error);
        for (int i = 0; i < ops.size(); i++) begin
            if (ops[i].is_free) begin
                run_free(i, ops[i]);
            end else begin
                run_alloc(i, ops[i]);
            end
        end
        repeat (4) @(posedge clk);
        $display("%0d operations, %0d errors", ops.size(), errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        while (rst !== 1'b0) @(posedge clk);
        repeat (200 * ops.size()) @(posedge clk);
        $display("timeout: the operations did not finish within %0d cycles", 200 * ops.size());
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
hw/malloc_pkg.sv
hw/bitmap_if.sv
hw/class_fifo.sv
hw/free_list.sv
hw/bitmap_store.sv
hw/alloc_engine.sv
hw/free_engine.sv
hw/malloc_top.sv
test/clock_gen.sv
test/malloc_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module malloc_tb -f list.f -o malloc_sim \
    && { output="$(./obj_dir/malloc_sim 2>&1)"; printf '%s\n' "$output"; } \
    && grep -qx "Testbench passed" <<< "$output" \
    && echo "simulation run: ok" \
    || { echo "simulation run: not ok"; exit 1; }
